// ==== sources.f ====
+incdir+rtl
rtl/calc_data_pkg.sv
rtl/calc_cmd_pkg.sv
rtl/button_debouncer.sv
rtl/entry_sequencer.sv
rtl/int_arith.sv
rtl/int_logic.sv
rtl/result_bank.sv
rtl/calc_top.sv
verification/calc_chk.sv
verification/calc_tb.sv

// ==== verification/calc_tb.sv ====
////////////////////////////////////////
// calculator testbench: button entry,
// reference model and directed tests
////////////////////////////////////////

`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_tb;

    logic                         clk;
    logic                         rst;
    logic                         enable;
    logic [`CALC_CHUNK_W-1:0]     switches;
    calc_data_pkg::entry_prompt_e prompt;
    calc_data_pkg::calc_word_t    result;
    logic                         sign;
    logic                         done;

    // model of the four holding registers
    calc_data_pkg::calc_word_t reg_model [`CALC_NUM_REGS];
    calc_data_pkg::calc_word_t got_result;
    logic                      got_sign;
    int                        done_seen;
    int                        done_used;
    int                        errors;
    int                        test_errors;
    int                        tests_passed;
    int                        tests_failed;
    int                        seed;
    string                     test_name;

    calc_top dut_i (
        .clk(clk), .rst(rst), .enable(enable), .switches(switches),
        .prompt(prompt), .result(result), .sign(sign), .done(done)
    );

    // the checker needs the size select, which only lives inside the top level
    bind calc_top calc_chk chk_i (
        .clk(clk), .rst(rst), .done(done), .sign(sign), .result(result),
        .prompt(prompt), .size(cmd.size)
    );

    always #20 clk = ~clk;

    // done may rise while the last press is still being released, so catch it here
    always @(negedge clk) begin
        if (!rst && done) begin
            done_seen++;
            got_result = result;
            got_sign   = sign;
        end
    end

    // inputs are driven and outputs read a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // eight cycles high and eight low get through the debounce filter both ways
    task automatic press_button(input logic [`CALC_CHUNK_W-1:0] value);
        switches = value;
        enable   = 1'b1;
        repeat (8) next_cycle();
        enable = 1'b0;
        repeat (8) next_cycle();
    endtask

    task automatic wait_prompt(input calc_data_pkg::entry_prompt_e want);
        int n;
        n = 0;
        while (prompt != want && n < 50) begin
            next_cycle();
            n++;
        end
        if (prompt != want) begin
            $display("Timeout in %s: prompt never reached %s", test_name, want.name());
            errors++;
        end
    endtask

    // keep size+1 chunks and clear everything above them
    function automatic calc_data_pkg::calc_word_t trunc_width(
        input calc_data_pkg::calc_word_t v, input int size);
        int width;
        width = `CALC_CHUNK_W * (size + 1);
        if (width >= `CALC_WORD_W) begin
            return v;
        end
        return v & ~({`CALC_WORD_W{1'b1}} << width);
    endfunction

    function automatic calc_data_pkg::calc_word_t arith_ref(
        input int op, input calc_data_pkg::calc_word_t a, input calc_data_pkg::calc_word_t b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a * b;
            // a zero divisor gives all ones, and the dividend as remainder
            3: return (b == 0) ? {`CALC_WORD_W{1'b1}} : a / b;
            4: return (b == 0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    function automatic calc_data_pkg::calc_word_t logic_ref(
        input int op, input calc_data_pkg::calc_word_t a, input calc_data_pkg::calc_word_t b);
        case (op)
            0: return a & b;
            1: return ~(a & b);
            2: return a | b;
            3: return ~(a | b);
            4: return a ^ b;
            5: return ~(a ^ b);
            6: return ~a;
            default: return '0;
        endcase
    endfunction

    // walks the prompts in the order the entry rules give and presses at each
    task automatic enter_command(input int cls, input int op, input int size,
                                 input calc_data_pkg::calc_word_t a,
                                 input calc_data_pkg::calc_word_t b);
        logic need_b;
        need_b = (cls == 0) || (cls == 1 && op != 6);
        wait_prompt(calc_data_pkg::pick_class);
        press_button(16'(cls));
        wait_prompt(calc_data_pkg::pick_op);
        press_button(16'(op));
        wait_prompt(calc_data_pkg::pick_size);
        press_button(16'(size));
        for (int k = 0; k <= size && cls != 2; k++) begin
            wait_prompt(calc_data_pkg::enter_a);
            press_button(a[k * `CALC_CHUNK_W +: `CALC_CHUNK_W]);
        end
        for (int k = 0; k <= size && need_b; k++) begin
            wait_prompt(calc_data_pkg::enter_b);
            press_button(b[k * `CALC_CHUNK_W +: `CALC_CHUNK_W]);
        end
        // with the B step skipped, entry is already back at the class step here
        assert (prompt == calc_data_pkg::pick_class) else begin
            $display("Fail %s: prompt expected pick_class actual %s", test_name,
                     prompt.name());
            errors++;
        end
    endtask

    task automatic check_result(input int size, input calc_data_pkg::calc_word_t raw);
        calc_data_pkg::calc_word_t want;
        logic                      want_sign;
        int                        n;
        want      = trunc_width(raw, size);
        want_sign = want[`CALC_CHUNK_W * size + `CALC_CHUNK_W - 1];
        n         = 0;
        while (done_seen == done_used && n < 100) begin
            next_cycle();
            n++;
        end
        if (done_seen == done_used) begin
            $display("Timeout in %s: done never came after the command", test_name);
            errors++;
        end else begin
            done_used++;
            assert (got_result == want) else begin
                $display("Fail %s: result expected %h actual %h", test_name, want, got_result);
                errors++;
            end
            assert (got_sign == want_sign) else begin
                $display("Fail %s: sign expected %b actual %b", test_name, want_sign, got_sign);
                errors++;
            end
            assert (done_seen == done_used) else begin
                $display("Error in %s: more than one done pulse for one command", test_name);
                errors++;
            end
        end
    endtask

    // operands are cut to the width first, since only size+1 chunks get entered
    task automatic run_and_check(input int cls, input int op, input int size,
                                 input calc_data_pkg::calc_word_t a,
                                 input calc_data_pkg::calc_word_t b);
        calc_data_pkg::calc_word_t at;
        calc_data_pkg::calc_word_t bt;
        calc_data_pkg::calc_word_t raw;
        at = trunc_width(a, size);
        bt = trunc_width(b, size);
        case (cls)
            0: raw = arith_ref(op, at, bt);
            1: raw = logic_ref(op, at, bt);
            2: raw = reg_model[op % `CALC_NUM_REGS];
            default: begin
                raw = at;
                reg_model[op % `CALC_NUM_REGS] = at;
            end
        endcase
        enter_command(cls, op, size, a, b);
        check_result(size, raw);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        if (errors == test_errors) begin
            $display("test %s: passed", test_name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - test_errors);
            tests_failed++;
        end
    endtask

    task automatic after_reset();
        start_test("after_reset");
        assert (prompt == calc_data_pkg::pick_class) else begin
            $display("Fail %s: prompt expected pick_class actual %s", test_name, prompt.name());
            errors++;
        end
        assert (result == '0) else begin
            $display("Fail %s: result expected %h actual %h", test_name, 64'h0, result);
            errors++;
        end
        assert (sign == 1'b0 && done == 1'b0) else begin
            $display("Fail %s: sign and done expected 00 actual %b%b", test_name, sign, done);
            errors++;
        end
        finish_test();
    endtask

    // the 32-bit pass makes sub go negative in the low word
    task automatic add_sub_mul();
        start_test("add_sub_mul");
        for (int op = 0; op < 3; op++) begin
            run_and_check(0, op, 3, 64'h9abc_def0_1234_5678, 64'h0fed_cba9_8765_4321);
            run_and_check(0, op, 1, 64'h9abc_def0_1234_5678, 64'h0fed_cba9_8765_4321);
        end
        finish_test();
    endtask

    task automatic div_rem();
        start_test("div_rem");
        run_and_check(0, 3, 3, 64'h0123_4567_89ab_cdef, 64'd1000003);
        run_and_check(0, 4, 3, 64'h0123_4567_89ab_cdef, 64'd1000003);
        run_and_check(0, 3, 3, 64'h0123_4567_89ab_cdef, 64'd0);
        run_and_check(0, 4, 3, 64'h0123_4567_89ab_cdef, 64'd0);
        finish_test();
    endtask

    task automatic bitwise_ops();
        start_test("bitwise_ops");
        for (int op = 0; op < 7; op++) begin
            run_and_check(1, op, 3, 64'hf0f0_ff00_1234_a5a5, 64'h0ff0_f0f0_4321_5a5a);
        end
        finish_test();
    endtask

    task automatic reg_store_fetch();
        start_test("reg_store_fetch");
        // register 3 has not been written since reset
        run_and_check(2, 3, 3, '0, '0);
        for (int r = 0; r < `CALC_NUM_REGS; r++) begin
            run_and_check(3, r, 3, {$random(seed), $random(seed)}, '0);
        end
        for (int r = 0; r < `CALC_NUM_REGS; r++) begin
            run_and_check(2, r, 3, '0, '0);
        end
        finish_test();
    endtask

    task automatic chunk_placement();
        calc_data_pkg::calc_word_t a;
        calc_data_pkg::calc_word_t b;
        start_test("chunk_placement");
        for (int size = 0; size < 3; size += 2) begin
            repeat (3) begin
                a = {$random(seed), $random(seed)};
                b = {$random(seed), $random(seed)};
                run_and_check(0, 0, size, a, b);
                run_and_check(1, 4, size, a, b);
                assert ((got_result >> (`CALC_CHUNK_W * (size + 1))) == '0) else begin
                    $display("Fail %s: upper bits expected 0 actual %h", test_name,
                             got_result >> (`CALC_CHUNK_W * (size + 1)));
                    errors++;
                end
            end
        end
        finish_test();
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        enable   = 1'b0;
        switches = '0;
        seed     = 99;
        for (int r = 0; r < `CALC_NUM_REGS; r++) begin
            reg_model[r] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();
        after_reset();
        add_sub_mul();
        div_rem();
        bitwise_ops();
        reg_store_fetch();
        chunk_placement();
        if (dut_i.chk_i.fail_cnt != 0) begin
            $display("bound assertions failed %0d times", dut_i.chk_i.fail_cnt);
        end
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0 && dut_i.chk_i.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verification/calc_chk.sv ====
////////////////////////////////////////
// concurrent assertions on the outputs
// of calc_top, attached with bind
////////////////////////////////////////

`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_chk (
    input logic                         clk,
    input logic                         rst,
    input logic                         done,
    input logic                         sign,
    input calc_data_pkg::calc_word_t    result,
    input calc_data_pkg::entry_prompt_e prompt,
    input calc_data_pkg::size_sel_t     size
);

    logic top_bit;

    // number of assertion failures so far
    int fail_cnt = 0;

    // size counts chunks from zero, so the top bit sits at 16*(size+1)-1
    assign top_bit = result[`CALC_CHUNK_W * int'(size) + `CALC_CHUNK_W - 1];

    // done is a single cycle pulse per command
    done_pulse_a: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for two cycles");
            fail_cnt++;
        end

    // sign is taken from the truncated result, not from bit 63
    sign_bit_a: assert property (@(posedge clk) disable iff (rst) done |-> (sign == top_bit))
        else begin
            $error("sign does not match the top bit of the selected width");
            fail_cnt++;
        end

    // entry has already returned to the class step when the result shows
    prompt_idle_a: assert property (@(posedge clk) disable iff (rst)
        done |=> (prompt == calc_data_pkg::pick_class))
        else begin
            $error("prompt is not pick_class in the cycle after done");
            fail_cnt++;
        end

endmodule

// ==== rtl/calc_top.sv ====
////////////////////////////////////////
// calculator top level
////////////////////////////////////////

`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         enable,
    input  logic [`CALC_CHUNK_W-1:0]     switches,
    output calc_data_pkg::entry_prompt_e prompt,
    output calc_data_pkg::calc_word_t    result,
    output logic                         sign,
    output logic                         done
);

    logic                        press;
    logic                        cmd_valid;
    calc_cmd_pkg::calc_cmd_s     cmd;
    calc_data_pkg::unit_result_s arith_res;
    calc_data_pkg::unit_result_s logic_res;

    // input side, enable is the raw confirm button
    button_debouncer debounce_i (
        .clk(clk), .rst(rst), .button(enable), .press(press)
    );

    entry_sequencer seq_i (
        .clk(clk), .rst(rst), .press(press), .switches(switches),
        .prompt(prompt), .cmd(cmd), .cmd_valid(cmd_valid)
    );

    // both units see every command and filter on the class
    int_arith arith_i (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .res(arith_res)
    );

    int_logic logic_i (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .res(logic_res)
    );

    result_bank bank_i (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid),
        .arith_res(arith_res), .logic_res(logic_res),
        .result(result), .sign(sign), .done(done)
    );

endmodule

// ==== rtl/result_bank.sv ====
////////////////////////////////////////
// holding registers, result selection,
// width truncation, sign and done
////////////////////////////////////////

`timescale 1ns/1ps
`include "calc_defines.svh"

module result_bank (
    input  logic                        clk,
    input  logic                        rst,
    input  calc_cmd_pkg::calc_cmd_s     cmd,
    input  logic                        cmd_valid,
    input  calc_data_pkg::unit_result_s arith_res,
    input  calc_data_pkg::unit_result_s logic_res,
    output calc_data_pkg::calc_word_t   result,
    output logic                        sign,
    output logic                        done
);

    localparam int NUM_CHUNKS = `CALC_WORD_W / `CALC_CHUNK_W;

    calc_data_pkg::calc_word_t regs [`CALC_NUM_REGS];
    calc_data_pkg::calc_word_t pick;
    calc_data_pkg::calc_word_t mask;
    calc_data_pkg::calc_word_t trunc;
    logic                      is_rf;
    logic                      rf_valid;
    logic                      pick_valid;
    logic                      trunc_top;

    assign is_rf = (cmd.cls == calc_cmd_pkg::class_fetch) ||
                   (cmd.cls == calc_cmd_pkg::class_store);

    // fetch and store wait one cycle so they line up with the unit outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            rf_valid <= 1'b0;
        end else begin
            rf_valid <= cmd_valid && is_rf;
        end
    end

    assign pick_valid = arith_res.valid || logic_res.valid || rf_valid;

    // cmd is still held here, the next command needs several presses
    always_comb begin
        if (arith_res.valid) begin
            pick = arith_res.value;
        end else if (logic_res.valid) begin
            pick = logic_res.value;
        end else if (cmd.cls == calc_cmd_pkg::class_store) begin
            pick = cmd.a;
        end else begin
            pick = regs[cmd.op.reg_sel.idx];
        end
    end

    // keep size+1 chunks, upper bits read as zero
    always_comb begin
        mask      = {`CALC_WORD_W{1'b1}} >> (`CALC_CHUNK_W * (NUM_CHUNKS - 1 - int'(cmd.size)));
        trunc     = pick & mask;
        trunc_top = trunc[`CALC_CHUNK_W * (int'(cmd.size) + 1) - 1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CALC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            result <= '0;
            sign   <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= pick_valid;
            if (pick_valid) begin
                result <= trunc;
                sign   <= trunc_top;
            end
            // the store lands in the same edge that raises done
            if (rf_valid && (cmd.cls == calc_cmd_pkg::class_store)) begin
                regs[cmd.op.reg_sel.idx] <= cmd.a;
            end
        end
    end

endmodule

// ==== rtl/int_logic.sv ====
////////////////////////////////////////
// registered bitwise logic operations
////////////////////////////////////////

`timescale 1ns/1ps

module int_logic (
    input  logic                        clk,
    input  logic                        rst,
    input  calc_cmd_pkg::calc_cmd_s     cmd,
    input  logic                        cmd_valid,
    output calc_data_pkg::unit_result_s res
);

    calc_data_pkg::calc_word_t value_nxt;
    logic                      hit;

    assign hit = cmd_valid && (cmd.cls == calc_cmd_pkg::class_logic);

    // the op word is read through its logic view of the union
    always_comb begin
        case (cmd.op.logic_op)
            calc_cmd_pkg::logic_and:  value_nxt = cmd.a & cmd.b;
            calc_cmd_pkg::logic_nand: value_nxt = ~(cmd.a & cmd.b);
            calc_cmd_pkg::logic_or:   value_nxt = cmd.a | cmd.b;
            calc_cmd_pkg::logic_nor:  value_nxt = ~(cmd.a | cmd.b);
            calc_cmd_pkg::logic_xor:  value_nxt = cmd.a ^ cmd.b;
            calc_cmd_pkg::logic_xnor: value_nxt = ~(cmd.a ^ cmd.b);
            // not is unary, operand B was never entered
            calc_cmd_pkg::logic_not:  value_nxt = ~cmd.a;
            default:                  value_nxt = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= hit;
        end
        if (hit) begin
            res.value <= value_nxt;
        end
    end

endmodule

// ==== rtl/int_arith.sv ====
////////////////////////////////////////
// registered integer add, sub, mul,
// div and rem
////////////////////////////////////////

`timescale 1ns/1ps

module int_arith (
    input  logic                        clk,
    input  logic                        rst,
    input  calc_cmd_pkg::calc_cmd_s     cmd,
    input  logic                        cmd_valid,
    output calc_data_pkg::unit_result_s res
);

    calc_data_pkg::calc_word_t value_nxt;
    logic                      hit;

    // the unit only answers commands of its own class
    assign hit = cmd_valid && (cmd.cls == calc_cmd_pkg::class_arith);

    always_comb begin
        case (cmd.op.arith_op)
            calc_cmd_pkg::arith_add: value_nxt = cmd.a + cmd.b;
            calc_cmd_pkg::arith_sub: value_nxt = cmd.a - cmd.b;
            // only the low word of the product is kept
            calc_cmd_pkg::arith_mul: value_nxt = cmd.a * cmd.b;
            // divide by zero saturates the quotient
            calc_cmd_pkg::arith_div: value_nxt = (cmd.b == '0) ? '1 : cmd.a / cmd.b;
            // and leaves the dividend as the remainder
            calc_cmd_pkg::arith_rem: value_nxt = (cmd.b == '0) ? cmd.a : cmd.a % cmd.b;
            default:                 value_nxt = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= hit;
        end
        if (hit) begin
            res.value <= value_nxt;
        end
    end

endmodule

// ==== rtl/entry_sequencer.sv ====
////////////////////////////////////////
// entry step machine, collects class,
// operation, size and operand chunks
////////////////////////////////////////

`timescale 1ns/1ps
`include "calc_defines.svh"

module entry_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         press,
    input  logic [`CALC_CHUNK_W-1:0]     switches,
    output calc_data_pkg::entry_prompt_e prompt,
    output calc_cmd_pkg::calc_cmd_s      cmd,
    output logic                         cmd_valid
);

    // fields being entered, kept apart from cmd so cmd holds until the next issue
    calc_cmd_pkg::calc_cmd_s      work;
    calc_cmd_pkg::calc_cmd_s      work_nxt;
    calc_data_pkg::entry_prompt_e prompt_nxt;
    calc_data_pkg::size_sel_t     chunk;
    calc_data_pkg::size_sel_t     chunk_nxt;
    logic                         last_chunk;
    logic                         skip_a;
    logic                         skip_b;
    logic                         issue;

    // the chunk counter runs up to the size select, both count from zero
    assign last_chunk = (chunk == work.size);

    // fetch needs no operand at all
    assign skip_a = (work.cls == calc_cmd_pkg::class_fetch);

    // store and logic not work on operand A only
    assign skip_b = skip_a ||
                    (work.cls == calc_cmd_pkg::class_store) ||
                    ((work.cls == calc_cmd_pkg::class_logic) &&
                     (work.op.logic_op == calc_cmd_pkg::logic_not));

    always_comb begin
        work_nxt   = work;
        prompt_nxt = prompt;
        chunk_nxt  = chunk;
        issue      = 1'b0;
        if (press) begin
            case (prompt)
                calc_data_pkg::pick_class: begin
                    // a new command starts with both operands cleared
                    work_nxt     = '0;
                    work_nxt.cls = calc_cmd_pkg::calc_class_e'(switches[1:0]);
                    prompt_nxt   = calc_data_pkg::pick_op;
                end
                calc_data_pkg::pick_op: begin
                    work_nxt.op = calc_cmd_pkg::calc_op_u'(switches[2:0]);
                    prompt_nxt  = calc_data_pkg::pick_size;
                end
                calc_data_pkg::pick_size: begin
                    work_nxt.size = switches[1:0];
                    chunk_nxt     = '0;
                    if (skip_a) begin
                        issue      = 1'b1;
                        prompt_nxt = calc_data_pkg::pick_class;
                    end else begin
                        prompt_nxt = calc_data_pkg::enter_a;
                    end
                end
                calc_data_pkg::enter_a: begin
                    // chunk k lands in its own 16-bit slice
                    work_nxt.a[chunk * `CALC_CHUNK_W +: `CALC_CHUNK_W] = switches;
                    if (!last_chunk) begin
                        chunk_nxt = chunk + 2'd1;
                    end else if (skip_b) begin
                        issue      = 1'b1;
                        prompt_nxt = calc_data_pkg::pick_class;
                    end else begin
                        chunk_nxt  = '0;
                        prompt_nxt = calc_data_pkg::enter_b;
                    end
                end
                calc_data_pkg::enter_b: begin
                    work_nxt.b[chunk * `CALC_CHUNK_W +: `CALC_CHUNK_W] = switches;
                    if (!last_chunk) begin
                        chunk_nxt = chunk + 2'd1;
                    end else begin
                        issue      = 1'b1;
                        prompt_nxt = calc_data_pkg::pick_class;
                    end
                end
                default: begin
                    prompt_nxt = calc_data_pkg::pick_class;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prompt    <= calc_data_pkg::pick_class;
            chunk     <= '0;
            cmd_valid <= 1'b0;
        end else begin
            prompt    <= prompt_nxt;
            chunk     <= chunk_nxt;
            cmd_valid <= issue;
        end
        work <= work_nxt;
        // the last press is already folded into work_nxt
        if (issue) begin
            cmd <= work_nxt;
        end
    end

endmodule

// ==== rtl/button_debouncer.sv ====
////////////////////////////////////////
// confirm button synchronizer and
// debouncer with a press pulse
////////////////////////////////////////

`timescale 1ns/1ps
`include "calc_defines.svh"

module button_debouncer (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic press
);

    localparam int CNT_W = $clog2(`CALC_DEBOUNCE_CYCLES + 1);

    logic [1:0]       sync;
    logic             sample;
    logic             stable;
    logic [CNT_W-1:0] cnt;

    // the second flop is the first one safe to use in the clock domain
    assign sample = sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            sync   <= 2'b00;
            stable <= 1'b0;
            cnt    <= '0;
            press  <= 1'b0;
        end else begin
            sync  <= {sync[0], button};
            press <= 1'b0;
            // any sample equal to the accepted level restarts the count
            if (sample == stable) begin
                cnt <= '0;
            end else if (cnt == CNT_W'(`CALC_DEBOUNCE_CYCLES - 1)) begin
                cnt    <= '0;
                stable <= sample;
                // only the rising edge of the accepted level is a press
                press  <= sample;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/calc_cmd_pkg.sv ====
////////////////////////////////////////
// command types: class, operation union
// and the command struct
////////////////////////////////////////

package calc_cmd_pkg;

    // operation class, picked in the first entry step
    typedef enum logic [1:0] {
        class_arith,
        class_logic,
        class_fetch,
        class_store
    } calc_class_e;

    // integer arithmetic, codes 5 to 7 are unused
    typedef enum logic [2:0] {
        arith_add,
        arith_sub,
        arith_mul,
        arith_div,
        arith_rem
    } arith_op_e;

    // bitwise logic, code 7 is unused
    typedef enum logic [2:0] {
        logic_and,
        logic_nand,
        logic_or,
        logic_nor,
        logic_xor,
        logic_xnor,
        logic_not
    } logic_op_e;

    // register view of the operation word for fetch and store
    typedef struct packed {
        logic       spare;
        logic [1:0] idx;
    } reg_sel_s;

    // the one operation word the user enters, read according to the class
    typedef union packed {
        arith_op_e arith_op;
        logic_op_e logic_op;
        reg_sel_s  reg_sel;
    } calc_op_u;

    // complete command as handed to the processing units
    typedef struct packed {
        calc_class_e              cls;
        calc_op_u                 op;
        calc_data_pkg::size_sel_t size;
        calc_data_pkg::calc_word_t a;
        calc_data_pkg::calc_word_t b;
    } calc_cmd_s;

endpackage

// ==== rtl/calc_data_pkg.sv ====
////////////////////////////////////////
// data types: word, size select, entry
// prompt and the unit result struct
////////////////////////////////////////

`include "calc_defines.svh"

package calc_data_pkg;

    // one operand, result or holding register value
    typedef logic [`CALC_WORD_W-1:0] calc_word_t;

    // n selects n+1 chunks, so 16, 32, 48 or 64 bits
    typedef logic [1:0] size_sel_t;

    // entry step that is waiting for the next press
    typedef enum logic [2:0] {
        pick_class,
        pick_op,
        pick_size,
        enter_a,
        enter_b
    } entry_prompt_e;

    // output of a processing unit, valid for one cycle
    typedef struct packed {
        logic       valid;
        calc_word_t value;
    } unit_result_s;

endpackage

// ==== rtl/calc_defines.svh ====
////////////////////////////////////////
// width, chunk, register-count and
// debounce macros for the calculator
////////////////////////////////////////

`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// operand, result and holding register width
`define CALC_WORD_W 64

// one switch chunk, entered per button press
`define CALC_CHUNK_W 16

// number of store and fetch holding registers
`define CALC_NUM_REGS 4

// consecutive equal button samples before the level is accepted
`define CALC_DEBOUNCE_CYCLES 4

`endif
